// ==== hdl/i2cPkg.sv ====
// Two-wire bus definitions
// Master FSM states, frame width and bit-phase numbering
package i2cPkg;

	// Master FSM
	typedef enum logic [2:0] {
		stIdle,						// Bus released
		stStart,					// SDA falls while SCL high
		stByte,						// Eight data bits, MSB first
		stAck,						// SDA released for the slave
		stStop						// SDA rises while SCL high
	} masterStateT;

	localparam int FRAME_BITS = 24;			// Address byte plus two data bytes
	localparam int PHASES = 4;			// Ticks per SCL bit
	localparam int PHASE_BITS = $clog2(PHASES);

	// Phase numbers inside one bit
	localparam logic [PHASE_BITS-1:0] PH_SETUP = PHASE_BITS'(0);	// SCL low, data set up
	localparam logic [PHASE_BITS-1:0] PH_RISE = PHASE_BITS'(1);	// SCL high
	localparam logic [PHASE_BITS-1:0] PH_SAMPLE = PHASE_BITS'(2);	// SCL high, ack sampled
	localparam logic [PHASE_BITS-1:0] PH_FALL = PHASE_BITS'(PHASES - 1);	// Last phase
endpackage

// ==== hdl/codecPkg.sv ====
// Audio codec definitions
// Slave address, word sizes and the power-up register table
package codecPkg;

	localparam logic [7:0] SLAVE_ADDR = 8'h34;	// Write address, R/W bit low
	localparam int TABLE_LEN = 11;
	localparam int WORD_BITS = 16;			// 7-bit register index, 9-bit value

	// Init table, one register word per index
	function automatic logic [WORD_BITS-1:0] initWord(input int unsigned idx);
		case (idx)
			0:		initWord = 16'h0000;	// Dummy write, wakes the bus
			1:		initWord = 16'h001A;	// Left line-in volume
			2:		initWord = 16'h021A;	// Right line-in volume
			3:		initWord = 16'h0479;	// Left headphone volume
			4:		initWord = 16'h0679;	// Right headphone volume
			5:		initWord = 16'h08F8;	// Analog path, DAC selected
			6:		initWord = 16'h0A06;	// Digital path, de-emphasis
			7:		initWord = 16'h0C00;	// Power, all blocks on
			8:		initWord = 16'h0E01;	// Data format, 16 bit
			9:		initWord = 16'h1009;	// Sample rate
			10:		initWord = 16'h1201;	// Activate interface
			default:	initWord = 16'h0000;
		endcase
	endfunction
endpackage

// ==== hdl/i2cTickGen.sv ====
// Bus tick generator
// One-cycle enable at PHASES times the SCL rate
module i2cTickGen #(
	parameter int CLK_FREQ = 50_000_000,
	parameter int BUS_FREQ = 100_000
) (
	input  logic iCLK,
	input  logic iRST_N,
	output logic tick
);

	localparam int DIV = CLK_FREQ / (BUS_FREQ * i2cPkg::PHASES);
	localparam int CNT_BITS = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_BITS-1:0] divCnt;			// Cycles since last tick

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			divCnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= (divCnt == CNT_BITS'(DIV - 1));	// Reload cycle
			divCnt <= (divCnt == CNT_BITS'(DIV - 1)) ? '0 : divCnt + 1'b1;
		end
	end
endmodule

// ==== hdl/i2cMaster.sv ====
// Two-wire bus master, write only
// Start, three bytes each followed by an ack bit, then stop
// SDA modelled open drain through a low-drive enable
module i2cMaster (
	input  logic iCLK,
	input  logic iRST_N,
	input  logic tick,
	input  logic start,
	input  logic [i2cPkg::FRAME_BITS-1:0] frame,
	output logic done,
	output logic nack,
	output logic scl,
	output logic sdaOe,
	input  logic sdaIn
);

	i2cPkg::masterStateT state;
	logic [i2cPkg::PHASE_BITS-1:0] phase;		// Position inside current bit
	logic [2:0] bitCnt;				// Data bits left in byte
	logic [1:0] byteCnt;				// Byte being sent
	logic [i2cPkg::FRAME_BITS-1:0] shiftReg;	// MSB is the bit on the wire
	logic nackSticky;				// Any ack bit seen high
	logic lastPhase;

	assign lastPhase = (phase == i2cPkg::PH_FALL);
	assign nack = done && nackSticky;		// Only meaningful with done

	////////////////////
	// Sequencing, one phase per tick
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			state <= i2cPkg::stIdle;
			phase <= '0;
			bitCnt <= '0;
			byteCnt <= '0;
			nackSticky <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (state == i2cPkg::stIdle)
			begin
				if (start)
				begin
					state <= i2cPkg::stStart;
					phase <= '0;
					nackSticky <= 1'b0;	// New frame, new result
				end
			end
			else if (tick)
			begin
				phase <= lastPhase ? '0 : phase + 1'b1;
				case (state)
					i2cPkg::stStart:
						if (lastPhase)
						begin
							state <= i2cPkg::stByte;
							bitCnt <= 3'd7;
							byteCnt <= 2'd0;
						end
					i2cPkg::stByte:
						if (lastPhase)
						begin
							if (bitCnt == 3'd0)
								state <= i2cPkg::stAck;
							else
								bitCnt <= bitCnt - 1'b1;
						end
					i2cPkg::stAck:
					begin
						// Refusal is remembered, rest of frame still goes out
						if (phase == i2cPkg::PH_SAMPLE && sdaIn)
							nackSticky <= 1'b1;
						if (lastPhase)
						begin
							if (byteCnt == 2'd2)
								state <= i2cPkg::stStop;
							else
							begin
								state <= i2cPkg::stByte;
								byteCnt <= byteCnt + 1'b1;
								bitCnt <= 3'd7;
							end
						end
					end
					i2cPkg::stStop:
						if (lastPhase)
						begin
							state <= i2cPkg::stIdle;
							done <= 1'b1;
						end
					default:	state <= i2cPkg::stIdle;
				endcase
			end
		end
	end

	// Frame shifter
	always_ff @(posedge iCLK)
	begin
		if (state == i2cPkg::stIdle && start)
			shiftReg <= frame;
		else if (tick && state == i2cPkg::stByte && lastPhase)
			shiftReg <= {shiftReg[i2cPkg::FRAME_BITS-2:0], 1'b0};
	end

	////////////////////
	// Line levels
	always_comb
	begin
		scl = 1'b1;
		sdaOe = 1'b0;
		case (state)
			i2cPkg::stStart:
			begin
				scl = !lastPhase;			// Low before first data bit
				sdaOe = (phase != i2cPkg::PH_SETUP);	// Falls with SCL high
			end
			i2cPkg::stByte:
			begin
				scl = (phase == i2cPkg::PH_RISE) || (phase == i2cPkg::PH_SAMPLE);
				sdaOe = !shiftReg[i2cPkg::FRAME_BITS-1];	// Drive low for a zero
			end
			i2cPkg::stAck:
				scl = (phase == i2cPkg::PH_RISE) || (phase == i2cPkg::PH_SAMPLE);
			i2cPkg::stStop:
			begin
				scl = (phase != i2cPkg::PH_SETUP);
				sdaOe = (phase == i2cPkg::PH_SETUP) || (phase == i2cPkg::PH_RISE);
			end
			default:	;
		endcase
	end

	// Arbiter must only start an idle master
	startInIdle: assert property (@(posedge iCLK) disable iff (!iRST_N)
		start |-> state == i2cPkg::stIdle);

	// Data only moves while SCL is low, start and stop excepted
	sdaStableHigh: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(scl && $past(scl) && !(state inside {i2cPkg::stStart, i2cPkg::stStop}))
		|-> $stable(sdaOe));
endmodule

// ==== hdl/codecInitSeq.sv ====
// Codec power-up sequencer
// One bus frame per table word, resent until acknowledged
module codecInitSeq (
	input  logic iCLK,
	input  logic iRST_N,
	output logic req,
	output logic [i2cPkg::FRAME_BITS-1:0] frame,
	input  logic grant,
	input  logic done,
	input  logic nack,
	output logic initDone
);

	localparam int IDX_BITS = $clog2(codecPkg::TABLE_LEN);
	localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(codecPkg::TABLE_LEN - 1);

	logic [IDX_BITS-1:0] index;			// Table word in flight

	// Frame follows the index, stable until done
	assign frame = {codecPkg::SLAVE_ADDR, codecPkg::initWord(index)};
	assign req = !initDone;				// Requests until table is through

	////////////////////
	// Table walk
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			index <= '0;
			initDone <= 1'b0;
		end
		else if (grant && done)
		begin
			if (!nack)				// Refused word keeps its index
			begin
				if (index == LAST_IDX)
					initDone <= 1'b1;	// Req drops for good
				else
					index <= index + 1'b1;
			end
		end
	end

	// No frame is granted once the table is written
	noGrantAfterInit: assert property (@(posedge iCLK) disable iff (!iRST_N)
		initDone |-> !grant);
endmodule

// ==== hdl/hostWriteQueue.sv ====
// Host register word queue
// Credit returned when the head word is granted the bus
module hostWriteQueue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic iCLK,
	input  logic iRST_N,
	input  logic hostValid,
	input  logic [codecPkg::WORD_BITS-1:0] hostWord,
	output logic hostCredit,
	output logic hostNack,
	output logic req,
	output logic [i2cPkg::FRAME_BITS-1:0] frame,
	input  logic grant,
	input  logic done,
	input  logic nack
);

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(QUEUE_DEPTH - 1);

	logic [codecPkg::WORD_BITS-1:0] mem [QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [CNT_BITS-1:0] count;			// Occupancy
	logic busy;					// Popped word still on the bus
	logic pop;

	assign pop = grant && !busy;			// First cycle of the grant
	assign hostCredit = pop;
	assign hostNack = grant && done && nack;	// Word dropped, no retry
	assign req = busy || (count != '0);

	always_ff @(posedge iCLK)
	begin
		if (hostValid)
			mem[wrPtr] <= hostWord;
		if (pop)
			frame <= {codecPkg::SLAVE_ADDR, mem[rdPtr]};	// Ready for start
	end

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			busy <= 1'b0;
		end
		else
		begin
			if (hostValid)
				wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
			case ({hostValid, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	;
			endcase
			if (pop)
				busy <= 1'b1;
			else if (grant && done)
				busy <= 1'b0;
		end
	end

	// Credits keep the host off a full queue
	noPushFull: assert property (@(posedge iCLK) disable iff (!iRST_N)
		hostValid |-> count != CNT_BITS'(QUEUE_DEPTH));

	// Arbiter grants only a queue holding a word
	noPopEmpty: assert property (@(posedge iCLK) disable iff (!iRST_N)
		pop |-> count != '0);
endmodule

// ==== hdl/busArbiter.sv ====
// Two-way bus arbiter
// Grant held for one frame, alternating when both request
module busArbiter (
	input  logic iCLK,
	input  logic iRST_N,
	input  logic reqInit,
	input  logic reqHost,
	input  logic [i2cPkg::FRAME_BITS-1:0] frameInit,
	input  logic [i2cPkg::FRAME_BITS-1:0] frameHost,
	output logic grantInit,
	output logic grantHost,
	output logic start,
	output logic [i2cPkg::FRAME_BITS-1:0] frame,
	input  logic done,
	output logic doneInit,
	output logic doneHost
);

	logic lastHost;					// Host served last
	logic anyGrant;
	logic anyGrantD;

	assign anyGrant = grantInit || grantHost;
	assign frame = grantHost ? frameHost : frameInit;
	assign doneInit = done && grantInit;
	assign doneHost = done && grantHost;

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			grantInit <= 1'b0;
			grantHost <= 1'b0;
			lastHost <= 1'b0;
			anyGrantD <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			anyGrantD <= anyGrant;
			start <= anyGrant && !anyGrantD;	// One cycle after grant
			if (done)
			begin
				grantInit <= 1'b0;		// Frame over, bus free next cycle
				grantHost <= 1'b0;
			end
			else if (!anyGrant)
			begin
				if (reqInit && (!reqHost || lastHost))
				begin
					grantInit <= 1'b1;
					lastHost <= 1'b0;
				end
				else if (reqHost)
				begin
					grantHost <= 1'b1;
					lastHost <= 1'b1;
				end
			end
		end
	end

	grantOneHot: assert property (@(posedge iCLK) disable iff (!iRST_N)
		$onehot0({grantInit, grantHost}));
endmodule

// ==== hdl/codecConfigTop.sv ====
// Codec configuration subsystem
// Tick generator, bus master, init sequencer, host queue and arbiter
module codecConfigTop #(
	parameter int CLK_FREQ = 50_000_000,
	parameter int BUS_FREQ = 100_000,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic iCLK,
	input  logic iRST_N,
	input  logic hostValid,
	input  logic [codecPkg::WORD_BITS-1:0] hostWord,
	output logic hostCredit,
	output logic hostNack,
	output logic initDone,
	output logic i2cScl,
	output logic i2cSdaOe,
	input  logic i2cSdaIn
);

	logic tick;
	logic start;
	logic done;
	logic nack;					// Shared by both requesters
	logic [i2cPkg::FRAME_BITS-1:0] frame;
	logic reqInit, reqHost;
	logic grantInit, grantHost;
	logic doneInit, doneHost;
	logic [i2cPkg::FRAME_BITS-1:0] frameInit, frameHost;

	////////////////////
	// Bit level
	i2cTickGen #(.CLK_FREQ(CLK_FREQ), .BUS_FREQ(BUS_FREQ)) u_tickGen (
		.iCLK(iCLK), .iRST_N(iRST_N), .tick(tick));

	i2cMaster u_master (
		.iCLK(iCLK), .iRST_N(iRST_N), .tick(tick),
		.start(start), .frame(frame), .done(done), .nack(nack),
		.scl(i2cScl), .sdaOe(i2cSdaOe), .sdaIn(i2cSdaIn));

	////////////////////
	// Requesters and arbiter
	codecInitSeq u_initSeq (
		.iCLK(iCLK), .iRST_N(iRST_N), .req(reqInit), .frame(frameInit),
		.grant(grantInit), .done(doneInit), .nack(nack), .initDone(initDone));

	hostWriteQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_hostQueue (
		.iCLK(iCLK), .iRST_N(iRST_N), .hostValid(hostValid), .hostWord(hostWord),
		.hostCredit(hostCredit), .hostNack(hostNack), .req(reqHost), .frame(frameHost),
		.grant(grantHost), .done(doneHost), .nack(nack));

	busArbiter u_arbiter (
		.iCLK(iCLK), .iRST_N(iRST_N),
		.reqInit(reqInit), .reqHost(reqHost),
		.frameInit(frameInit), .frameHost(frameHost),
		.grantInit(grantInit), .grantHost(grantHost),
		.start(start), .frame(frame), .done(done),
		.doneInit(doneInit), .doneHost(doneHost));
endmodule

// ==== tests/i2cSlaveModel.sv ====
// Two-wire bus slave standing in for the codec
// Decodes write frames, acks or refuses each byte, reports every frame at its stop
module i2cSlaveModel (
	input  logic iCLK,
	input  logic iRST_N,
	input  logic scl,
	input  logic sda,				// Wired-AND bus level
	input  logic refuse,				// Withhold ack while high
	output logic sdaLow,				// Slave pulls SDA low
	output logic frameValid,			// One cycle per stop
	output logic [23:0] frameData,			// Address byte, then word
	output logic frameAck,				// All three bytes acknowledged
	output logic frameComplete			// Exactly three bytes and acks seen
);
	timeunit 1ns;
	timeprecision 100ps;

	logic sclD;
	logic sdaD;
	logic inFrame;					// Between start and stop
	logic [3:0] bitCnt;				// 8 means ack clock comes next
	logic [1:0] byteCnt;
	logic [23:0] shiftReg;
	logic allAck;
	logic ackThis;

	// Address byte acked only if it is ours
	assign ackThis = !refuse && (byteCnt != 2'd0 || shiftReg[7:0] == codecPkg::SLAVE_ADDR);

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			sclD <= 1'b1;
			sdaD <= 1'b1;
			inFrame <= 1'b0;
			bitCnt <= '0;
			byteCnt <= '0;
			shiftReg <= '0;
			allAck <= 1'b0;
			sdaLow <= 1'b0;
			frameValid <= 1'b0;
			frameData <= '0;
			frameAck <= 1'b0;
			frameComplete <= 1'b0;
		end
		else
		begin
			sclD <= scl;
			sdaD <= sda;
			frameValid <= 1'b0;
			if (sclD && scl && sdaD && !sda)	// Start, SDA falls with SCL high
			begin
				inFrame <= 1'b1;
				bitCnt <= '0;
				byteCnt <= '0;
				allAck <= 1'b1;
			end
			else if (sclD && scl && !sdaD && sda)	// Stop
			begin
				if (inFrame)
				begin
					frameValid <= 1'b1;
					frameData <= shiftReg;
					frameAck <= allAck;
					// Only the stop's own SCL rise after the last ack
					frameComplete <= (byteCnt == 2'd3) && (bitCnt == 4'd1);
				end
				inFrame <= 1'b0;
			end
			else if (inFrame && !sclD && scl)	// Rising SCL
			begin
				if (bitCnt == 4'd8)
				begin
					bitCnt <= '0;			// Ack clock, own bit
					byteCnt <= byteCnt + 1'b1;
				end
				else if (byteCnt == 2'd3)
					bitCnt <= bitCnt + 1'b1;	// Clock rises past the third byte
				else
				begin
					shiftReg <= {shiftReg[22:0], sda};	// MSB first
					bitCnt <= bitCnt + 1'b1;
				end
			end
			else if (inFrame && sclD && !scl)	// Falling SCL
			begin
				if (bitCnt == 4'd8)
				begin
					sdaLow <= ackThis;		// Ack low, refusal leaves SDA high
					if (!ackThis)
						allAck <= 1'b0;
				end
				else
					sdaLow <= 1'b0;
			end
		end
	end
endmodule

// ==== tests/codecConfigTb.sv ====
// Testbench for the codec configuration subsystem
// Clock, reset, LFSR stimulus, bus slave, reference model and checks
module codecConfigTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_FREQ = 50_000_000;
	localparam int BUS_FREQ = 500_000;		// 25 cycles per tick, ~2900 per frame
	localparam int QUEUE_DEPTH = 4;
	localparam int HOST_WORDS = 24;
	localparam int WAIT_LIMIT = 400_000;		// Cycles allowed per wait

	logic iCLK = 1'b0;
	logic iRST_N = 1'b0;
	logic hostValid = 1'b0;
	logic [codecPkg::WORD_BITS-1:0] hostWord = '0;
	logic refuse = 1'b0;
	logic hostCredit, hostNack, initDone;
	logic i2cScl, i2cSdaOe, i2cSdaIn;
	logic slaveSdaLow;
	logic frameValid, frameAck, frameComplete;
	logic [23:0] frameData;

	// Reference model state
	logic [31:0] lfsr;
	logic [15:0] expHost[$];			// Host words pushed, not yet on the bus
	int credits, pushes, creditPulses;
	int initIdx, initRefused;			// Next table index expected
	int hostDuringInit, hostRefused, pendingNack, nackPulses;
	bit hostEnable, refuseEnable;
	int valueErrs, otherErrs;

	always #10 iCLK = !iCLK;

	assign i2cSdaIn = !(i2cSdaOe || slaveSdaLow);	// Open-drain bus, pulled up

	codecConfigTop #(.CLK_FREQ(CLK_FREQ), .BUS_FREQ(BUS_FREQ), .QUEUE_DEPTH(QUEUE_DEPTH))
	u_codecConfigTop (
		.iCLK(iCLK), .iRST_N(iRST_N), .hostValid(hostValid), .hostWord(hostWord),
		.hostCredit(hostCredit), .hostNack(hostNack), .initDone(initDone),
		.i2cScl(i2cScl), .i2cSdaOe(i2cSdaOe), .i2cSdaIn(i2cSdaIn));

	i2cSlaveModel u_slave (
		.iCLK(iCLK), .iRST_N(iRST_N), .scl(i2cScl), .sda(i2cSdaIn), .refuse(refuse),
		.sdaLow(slaveSdaLow), .frameValid(frameValid), .frameData(frameData),
		.frameAck(frameAck), .frameComplete(frameComplete));

	////////////////////
	// Random source, Galois form
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);			// One step per bit
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic reportProblem(input string msg);
		otherErrs++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			valueErrs++;
			$display("Fail at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
		end
	endtask

	////////////////////
	// One frame seen by the slave
	task automatic checkFrame();
		logic [15:0] word;
		logic [15:0] exp;
		logic [31:0] r;
		word = frameData[15:0];
		assert (frameComplete) else reportProblem("bus frame is not three whole bytes");
		checkValue("frame address", 32'(codecPkg::SLAVE_ADDR), 32'(frameData[23:16]));
		if (!word[15])					// Table words all below 8000
		begin
			assert (!initDone) else reportProblem("init frame after initDone");
			checkValue("init word", 32'(codecPkg::initWord(initIdx)), 32'(word));
			if (frameAck)
				initIdx++;
			else
				initRefused++;			// Same word must come again
		end
		else
		begin
			if (!initDone)
				hostDuringInit++;
			assert (expHost.size() != 0) else reportProblem("host frame with no word queued");
			if (expHost.size() != 0)
			begin
				exp = expHost.pop_front();
				checkValue("host word", 32'(exp), 32'(word));
			end
			if (!frameAck)
			begin
				hostRefused++;
				pendingNack++;			// One hostNack owed, no resend
			end
		end
		refuse = 1'b0;
		if (refuseEnable)
		begin
			drawBits(3, r);
			refuse = (r[2:0] == 3'd0);		// About one frame in eight
		end
	endtask

	// Observe outputs, then drive the host port
	task automatic stepModel();
		logic [31:0] r;
		if (!iRST_N)
		begin
			credits = QUEUE_DEPTH;
			pushes = 0;
			creditPulses = 0;
			initIdx = 0;
			initRefused = 0;
			hostDuringInit = 0;
			hostRefused = 0;
			pendingNack = 0;
			nackPulses = 0;
			expHost.delete();
			hostValid = 1'b0;
			refuse = 1'b0;
		end
		else
		begin
			if (hostNack)
			begin
				nackPulses++;
				assert (pendingNack > 0) else reportProblem("hostNack without refused frame");
				if (pendingNack > 0)
					pendingNack--;
			end
			if (frameValid)
				checkFrame();
			hostValid = 1'b0;
			if (hostEnable && credits > 0 && pushes < HOST_WORDS)
			begin
				drawBits(2, r);
				if (r[1:0] == 2'b00)
				begin
					drawBits(15, r);
					hostWord = {1'b1, r[14:0]};	// Top bit marks host words
					hostValid = 1'b1;
					credits--;
					pushes++;
					expHost.push_back(hostWord);
				end
			end
			// Credit returned this cycle is spent from the next one
			if (hostCredit)
			begin
				credits++;
				creditPulses++;
				assert (credits <= QUEUE_DEPTH) else reportProblem("hostCredit with no word out");
			end
		end
	endtask

	task automatic nextCycle();
		@(negedge iCLK);
		stepModel();
	endtask

	task automatic applyReset();
		iRST_N = 1'b0;
		repeat (16)
			nextCycle();
		iRST_N = 1'b1;					// Released on a falling edge
	endtask

	// Bus idle right after reset, well before the first tick
	task automatic checkIdleLines();
		nextCycle();
		checkValue("i2cScl", 32'd1, 32'(i2cScl));
		checkValue("i2cSdaOe", 32'd0, 32'(i2cSdaOe));
		checkValue("initDone", 32'd0, 32'(initDone));
		checkValue("hostCredit", 32'd0, 32'(hostCredit));
		checkValue("hostNack", 32'd0, 32'(hostNack));
	endtask

	task automatic waitInitDone();
		int n;
		n = 0;
		while (!initDone && n < WAIT_LIMIT)
		begin
			nextCycle();
			n++;
		end
		assert (initDone) else reportProblem("timeout waiting for initDone");
		checkValue("table words acked at initDone", codecPkg::TABLE_LEN, initIdx);
	endtask

	task automatic waitDrained();
		int n;
		n = 0;
		while ((pushes < HOST_WORDS || expHost.size() != 0 || pendingNack != 0)
			&& n < WAIT_LIMIT)
		begin
			nextCycle();
			n++;
		end
		assert (n < WAIT_LIMIT) else reportProblem("timeout waiting for host queue to drain");
	endtask

	////////////////////
	initial
	begin
		lfsr = 32'hb0f4;
		valueErrs = 0;
		otherErrs = 0;
		hostEnable = 1'b0;
		refuseEnable = 1'b0;

		// Table alone, every byte acked
		applyReset();
		checkIdleLines();
		waitInitDone();
		checkValue("init refusals", 32'd0, initRefused);

		// Refusals and host traffic from reset on
		hostEnable = 1'b1;
		refuseEnable = 1'b1;
		applyReset();
		checkIdleLines();
		waitInitDone();
		assert (hostDuringInit > 0) else reportProblem("no host frame on the bus during init");
		waitDrained();
		checkValue("hostCredit pulses", pushes, creditPulses);
		checkValue("model credits", QUEUE_DEPTH, credits);
		checkValue("hostNack pulses", hostRefused, nackPulses);

		$display("Init resends %0d, host words %0d, host refusals %0d",
			initRefused, pushes, hostRefused);
		$display("Errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
		if (valueErrs + otherErrs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end
endmodule

// ==== codecConfigTop.f ====
hdl/i2cPkg.sv
hdl/codecPkg.sv
hdl/i2cTickGen.sv
hdl/i2cMaster.sv
hdl/codecInitSeq.sv
hdl/hostWriteQueue.sv
hdl/busArbiter.sv
hdl/codecConfigTop.sv
tests/i2cSlaveModel.sv
tests/codecConfigTb.sv

// ==== Makefile ====
# Verilator build and run for the codec configuration subsystem

VERILATOR ?= verilator
TOP ?= codecConfigTb
FILELIST ?= codecConfigTop.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(OBJDIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJDIR)
